// ==== basics_pkg.sv ====
package basics_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] eid_t;
	typedef logic [23:0] gpio_t;
	typedef logic [15:0] i2c_addr_t;
	typedef logic [15:0] baud_div_t;
	typedef logic [7:0] i2c_speed_t;

	// Commands are sent as single ASCII bytes
	typedef enum logic [7:0] {
		CMD_NONE       = 8'h00,
		CMD_VERSION    = "v",
		CMD_QUERY_I2C  = "I",
		CMD_SET_I2C    = "i",
		CMD_QUERY_GPIO = "G",
		CMD_SET_GPIO   = "g",
		CMD_QUERY_UART = "P",
		CMD_SET_UART   = "p"
	} cmd_t;

	// Sub-parameter byte that follows a query or set command
	typedef enum logic [7:0] {
		SEL_NONE       = 8'h00,
		SEL_I2C_SPEED  = "c",
		SEL_I2C_ADDR   = "a",
		SEL_GPIO_LEVEL = "l",
		SEL_GPIO_DIR   = "d",
		SEL_UART_BAUD  = "b"
	} param_sel_t;

	localparam byte_t VERSION_MAJOR = 8'd0;
	localparam byte_t VERSION_MINOR = 8'd3;

	localparam byte_t CODE_ACK = 8'd0;
	localparam byte_t CODE_NAK = 8'd1;

	// Settings after reset
	localparam i2c_speed_t I2C_SPEED_RST = 8'd99;
	localparam i2c_addr_t I2C_ADDR_RST = 16'hFFFF;
	localparam gpio_t GPIO_LEVEL_RST = 24'h000000;
	localparam gpio_t GPIO_DIR_RST = 24'h000000;
	localparam baud_div_t BAUD_DIV_RST = 16'd174;

	// Output FIFO, depth must stay a power of two
	localparam int FIFO_DEPTH = 32;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// Header of three bytes plus the longest payload
	localparam int MAX_RESP_BYTES = 6;

endpackage

// ==== basics_ifs.sv ====
// Decoded command stream from the frame receiver
interface cmd_if;
	import basics_pkg::*;

	logic cmd_start;
	cmd_t cmd;
	eid_t eid;
	byte_t pay_data;
	logic pay_valid;

	modport rx (
		output cmd_start,
		output cmd,
		output eid,
		output pay_data,
		output pay_valid
	);

	modport seq (
		input cmd_start,
		input cmd,
		input eid,
		input pay_data,
		input pay_valid
	);
endinterface

// Parameter access between sequencer and settings bank
interface param_if;
	import basics_pkg::*;

	param_sel_t sel;
	byte_t wr_byte;
	logic wr_en;
	logic commit;
	// Value is right-aligned, rd_len counts its bytes
	logic [23:0] rd_value;
	logic [1:0] rd_len;

	modport seq (
		output sel,
		output wr_byte,
		output wr_en,
		output commit,
		input rd_value,
		input rd_len
	);

	modport bank (
		input sel,
		input wr_byte,
		input wr_en,
		input commit,
		output rd_value,
		output rd_len
	);
endinterface

// ==== frame_rx.sv ====
module frame_rx (
	input logic rst,
	input logic clk,
	input basics_pkg::byte_t ma_data,
	input logic ma_data_valid,
	input logic ma_frame_valid,
	cmd_if.rx cmd
);
	import basics_pkg::*;

	logic last_fv;
	logic frame_start;
	logic [1:0] hdr_cnt;
	logic seen_start;
	cmd_t cmd_dec;

	// Command byte sits on the bus when frame valid rises
	assign frame_start = ma_frame_valid & ~last_fv;

	always_comb begin
		case (ma_data)
			CMD_VERSION, CMD_QUERY_I2C, CMD_SET_I2C, CMD_QUERY_GPIO,
			CMD_SET_GPIO, CMD_QUERY_UART, CMD_SET_UART: cmd_dec = cmd_t'(ma_data);
			default: cmd_dec = CMD_NONE;
		endcase
	end

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			last_fv <= 1'b0;
			hdr_cnt <= 2'd0;
			seen_start <= 1'b0;
			cmd.cmd_start <= 1'b0;
			cmd.cmd <= CMD_NONE;
			cmd.pay_valid <= 1'b0;
		end else begin
			last_fv <= ma_frame_valid;
			cmd.cmd_start <= frame_start;
			cmd.pay_valid <= 1'b0;
			if (frame_start) begin
				cmd.cmd <= cmd_dec;
				hdr_cnt <= 2'd0;
				seen_start <= 1'b0;
			end else if (ma_frame_valid && ma_data_valid) begin
				// EID first, then the length byte which is skipped
				if (hdr_cnt != 2'd2) begin
					hdr_cnt <= hdr_cnt + 2'd1;
				end else begin
					cmd.pay_valid <= 1'b1;
				end
			end
			if (cmd.cmd_start) begin
				seen_start <= 1'b1;
			end
		end
	end

	always_ff @(posedge rst) begin
		if (!frame_start && ma_frame_valid && ma_data_valid && hdr_cnt == 2'd0) begin
			cmd.eid <= ma_data;
		end
		cmd.pay_data <= ma_data;
	end

	// Payload of a frame only after that frame's command
	pay_after_start: assert property (@(posedge rst) disable iff (clk)
		cmd.pay_valid |-> seen_start)
		else $error("payload forwarded before command start");

endmodule

// ==== basics_seq.sv ====
module basics_seq (
	input logic rst,
	input logic clk,
	input logic generate_nak,
	cmd_if.seq cmd,
	param_if.seq prm,
	output logic ack_start,
	output logic ack_nak,
	output basics_pkg::byte_t ack_len,
	output basics_pkg::eid_t eid_out,
	output basics_pkg::byte_t push_data,
	output logic push,
	output logic push_last,
	input logic fifo_free,
	input logic frames_pending
);
	import basics_pkg::*;

	typedef enum logic [3:0] {
		IDLE,
		WAIT_ROOM,
		VER_COLLECT,
		VER_DECIDE,
		SUB_DECODE,
		SEND_HDR,
		SEND_PAYLOAD,
		SET_COLLECT,
		SET_DRAIN,
		NAK_ONLY
	} state_t;

	state_t state;
	state_t next;
	logic [1:0] cnt;
	logic cnt_en;
	cmd_t cur_cmd;
	logic is_set;
	logic is_query;
	param_sel_t sub_sel;
	logic resp_nak;
	byte_t resp_len;
	logic [1:0] pay_left;
	logic [15:0] ver_in;
	// Payload bytes left-aligned, sent from the top byte
	logic [23:0] pay_sr;

	assign is_set = cur_cmd inside {CMD_SET_I2C, CMD_SET_GPIO, CMD_SET_UART};
	assign is_query = cur_cmd inside {CMD_QUERY_I2C, CMD_QUERY_GPIO, CMD_QUERY_UART};

	// Sub-parameter must belong to the command's group
	always_comb begin
		sub_sel = SEL_NONE;
		case (cur_cmd)
			CMD_QUERY_I2C, CMD_SET_I2C:
				if (cmd.pay_data == SEL_I2C_SPEED || cmd.pay_data == SEL_I2C_ADDR)
					sub_sel = param_sel_t'(cmd.pay_data);
			CMD_QUERY_GPIO, CMD_SET_GPIO:
				if (cmd.pay_data == SEL_GPIO_LEVEL || cmd.pay_data == SEL_GPIO_DIR)
					sub_sel = param_sel_t'(cmd.pay_data);
			CMD_QUERY_UART, CMD_SET_UART:
				if (cmd.pay_data == SEL_UART_BAUD)
					sub_sel = SEL_UART_BAUD;
			default: ;
		endcase
	end

	always_comb begin
		next = state;
		case (state)
			IDLE: begin
				if (generate_nak)
					next = NAK_ONLY;
				else if (cmd.cmd_start && cmd.cmd == CMD_VERSION)
					next = VER_COLLECT;
				else if (cmd.cmd_start && cmd.cmd != CMD_NONE)
					next = SUB_DECODE;
			end
			// The next frame only lends its EID
			NAK_ONLY: if (cmd.cmd_start) next = WAIT_ROOM;
			VER_COLLECT: if (cmd.pay_valid && cnt == 2'd1) next = VER_DECIDE;
			VER_DECIDE: next = WAIT_ROOM;
			SUB_DECODE: begin
				if (cmd.pay_valid)
					next = (is_set && sub_sel != SEL_NONE) ? SET_COLLECT : WAIT_ROOM;
			end
			SET_COLLECT: if (cmd.pay_valid && cnt + 2'd1 == prm.rd_len) next = WAIT_ROOM;
			WAIT_ROOM: if (fifo_free) next = SEND_HDR;
			// Header generator owns the FIFO for three cycles
			SEND_HDR: begin
				if (cnt == 2'd3) begin
					if (pay_left != 2'd0)
						next = SEND_PAYLOAD;
					else if (is_set && !resp_nak)
						next = SET_DRAIN;
					else
						next = IDLE;
				end
			end
			SEND_PAYLOAD: if (pay_left == 2'd1) next = IDLE;
			// Commit only after the ACK has left the FIFO
			SET_DRAIN: if (!frames_pending) next = IDLE;
			default: next = IDLE;
		endcase
	end

	assign cnt_en = state == SEND_HDR || cmd.pay_valid;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			state <= IDLE;
			cnt <= 2'd0;
			cur_cmd <= CMD_NONE;
			resp_nak <= 1'b0;
			resp_len <= 8'd0;
			pay_left <= 2'd0;
			prm.sel <= SEL_NONE;
		end else begin
			state <= next;
			if (next != state)
				cnt <= 2'd0;
			else if (cnt_en)
				cnt <= cnt + 2'd1;
			case (state)
				IDLE: begin
					if (generate_nak || cmd.cmd_start) begin
						cur_cmd <= generate_nak ? CMD_NONE : cmd.cmd;
						resp_nak <= generate_nak;
						resp_len <= 8'd0;
						pay_left <= 2'd0;
					end
				end
				VER_DECIDE: begin
					if (ver_in != {VERSION_MAJOR, VERSION_MINOR}) begin
						resp_nak <= 1'b1;
						resp_len <= 8'd2;
						pay_left <= 2'd2;
					end
				end
				SUB_DECODE: begin
					if (cmd.pay_valid) begin
						prm.sel <= sub_sel;
						resp_nak <= sub_sel == SEL_NONE;
					end
				end
				WAIT_ROOM: begin
					if (fifo_free && is_query && !resp_nak) begin
						resp_len <= {6'd0, prm.rd_len};
						pay_left <= prm.rd_len;
					end
				end
				SEND_PAYLOAD: pay_left <= pay_left - 2'd1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge rst) begin
		if (state == VER_COLLECT && cmd.pay_valid)
			ver_in <= {ver_in[7:0], cmd.pay_data};
		case (state)
			VER_DECIDE: pay_sr <= {VERSION_MAJOR, VERSION_MINOR, 8'h00};
			WAIT_ROOM: begin
				if (is_query) begin
					case (prm.rd_len)
						2'd1: pay_sr <= {prm.rd_value[7:0], 16'h0000};
						2'd2: pay_sr <= {prm.rd_value[15:0], 8'h00};
						default: pay_sr <= prm.rd_value;
					endcase
				end
			end
			SEND_PAYLOAD: pay_sr <= {pay_sr[15:0], 8'h00};
			default: ;
		endcase
	end

	assign ack_start = state == SEND_HDR && cnt == 2'd0;
	assign ack_nak = resp_nak;
	assign ack_len = resp_len;
	assign eid_out = cmd.eid;
	assign push = state == SEND_PAYLOAD;
	assign push_data = pay_sr[23:16];
	assign push_last = pay_left == 2'd1;
	assign prm.wr_en = state == SET_COLLECT && cmd.pay_valid;
	assign prm.wr_byte = cmd.pay_data;
	assign prm.commit = state == SET_DRAIN && !frames_pending;

	// Header bytes and payload never share a FIFO cycle
	hdr_before_payload: assert property (@(posedge rst) disable iff (clk)
		ack_start |=> !push [*3])
		else $error("payload push during header");

endmodule

// ==== param_bank.sv ====
module param_bank (
	input logic rst,
	input logic clk,
	input basics_pkg::gpio_t gpio_read,
	param_if.bank prm,
	output basics_pkg::i2c_speed_t i2c_speed,
	output basics_pkg::i2c_addr_t i2c_addr,
	output basics_pkg::gpio_t gpio_level,
	output basics_pkg::gpio_t gpio_direction,
	output basics_pkg::baud_div_t uart_baud_div
);
	import basics_pkg::*;

	// Shadow filled byte by byte, oldest byte ends up on top
	gpio_t staging;

	always_ff @(posedge rst) begin
		if (prm.wr_en) begin
			staging <= {staging[15:0], prm.wr_byte};
		end
	end

	// Read-out, level queries see the pins
	always_comb begin
		case (prm.sel)
			SEL_I2C_SPEED: begin
				prm.rd_value = {16'h0000, i2c_speed};
				prm.rd_len = 2'd1;
			end
			SEL_I2C_ADDR: begin
				prm.rd_value = {8'h00, i2c_addr};
				prm.rd_len = 2'd2;
			end
			SEL_GPIO_LEVEL: begin
				prm.rd_value = gpio_read;
				prm.rd_len = 2'd3;
			end
			SEL_GPIO_DIR: begin
				prm.rd_value = gpio_direction;
				prm.rd_len = 2'd3;
			end
			SEL_UART_BAUD: begin
				prm.rd_value = {8'h00, uart_baud_div};
				prm.rd_len = 2'd2;
			end
			default: begin
				prm.rd_value = 24'h000000;
				prm.rd_len = 2'd0;
			end
		endcase
	end

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			i2c_speed <= I2C_SPEED_RST;
			i2c_addr <= I2C_ADDR_RST;
			gpio_level <= GPIO_LEVEL_RST;
			gpio_direction <= GPIO_DIR_RST;
			uart_baud_div <= BAUD_DIV_RST;
		end else if (prm.commit) begin
			case (prm.sel)
				SEL_I2C_SPEED: i2c_speed <= staging[7:0];
				SEL_I2C_ADDR: i2c_addr <= staging[15:0];
				SEL_GPIO_LEVEL: gpio_level <= staging;
				SEL_GPIO_DIR: gpio_direction <= staging;
				SEL_UART_BAUD: uart_baud_div <= staging[15:0];
				default: ;
			endcase
		end
	end

endmodule

// ==== ack_generator.sv ====
module ack_generator (
	input logic rst,
	input logic clk,
	input logic start,
	input logic nak,
	input basics_pkg::eid_t eid,
	input basics_pkg::byte_t len,
	output basics_pkg::byte_t data,
	output logic push,
	output logic last,
	output logic busy
);
	import basics_pkg::*;

	// 0 is idle, 1 code, 2 EID, 3 length
	logic [1:0] cnt;
	logic nak_q;
	eid_t eid_q;
	byte_t len_q;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			cnt <= 2'd0;
		end else if (start || cnt != 2'd0) begin
			cnt <= cnt + 2'd1;
		end
	end

	always_ff @(posedge rst) begin
		if (start) begin
			nak_q <= nak;
			eid_q <= eid;
			len_q <= len;
		end
	end

	assign busy = cnt != 2'd0;
	assign push = busy;
	// Frame ends on the length byte only without payload
	assign last = cnt == 2'd3 && len_q == 8'd0;

	always_comb begin
		case (cnt)
			2'd1: data = nak_q ? CODE_NAK : CODE_ACK;
			2'd2: data = eid_q;
			default: data = len_q;
		endcase
	end

endmodule

// ==== message_fifo.sv ====
module message_fifo (
	input logic rst,
	input logic clk,
	input basics_pkg::byte_t in_data,
	input logic in_last,
	input logic push,
	input logic pop,
	output basics_pkg::byte_t out_data,
	output logic out_last,
	output logic frame_valid,
	output logic free
);
	import basics_pkg::*;

	byte_t mem_data [FIFO_DEPTH];
	logic mem_last [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0] count;
	// Complete frames held, counted by their last byte
	logic [FIFO_AW:0] frames;

	always_ff @(posedge rst) begin
		if (push) begin
			mem_data[wr_ptr] <= in_data;
			mem_last[wr_ptr] <= in_last;
		end
	end

	assign out_data = mem_data[rd_ptr];
	assign out_last = mem_last[rd_ptr];
	assign frame_valid = frames != '0;
	assign free = int'(count) <= FIFO_DEPTH - MAX_RESP_BYTES;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			frames <= '0;
		end else begin
			// Pointers wrap on their own
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({push && in_last, pop && out_last})
				2'b10: frames <= frames + 1'b1;
				2'b01: frames <= frames - 1'b1;
				default: frames <= frames;
			endcase
		end
	end

	no_overflow: assert property (@(posedge rst) disable iff (clk)
		push |-> int'(count) < FIFO_DEPTH)
		else $error("push into full FIFO");

	no_early_pop: assert property (@(posedge rst) disable iff (clk)
		pop |-> frame_valid)
		else $error("pop without a complete frame");

endmodule

// ==== basics_int.sv ====
module basics_int (
	input logic rst,
	input logic clk,
	input logic generate_nak,
	input basics_pkg::byte_t ma_data,
	input logic ma_data_valid,
	input logic ma_frame_valid,
	input basics_pkg::gpio_t gpio_read,
	input logic resp_pop,
	output basics_pkg::byte_t resp_data,
	output logic resp_last,
	output logic resp_frame_valid,
	output basics_pkg::i2c_speed_t i2c_speed,
	output basics_pkg::i2c_addr_t i2c_addr,
	output basics_pkg::gpio_t gpio_level,
	output basics_pkg::gpio_t gpio_direction,
	output basics_pkg::baud_div_t uart_baud_div
);
	import basics_pkg::*;

	cmd_if cmd_bus ();
	param_if prm_bus ();

	logic ack_start;
	logic ack_nak;
	byte_t ack_len;
	eid_t ack_eid;
	byte_t ack_data;
	logic ack_push;
	logic ack_last;
	logic ack_busy;
	byte_t seq_data;
	logic seq_push;
	logic seq_last;
	byte_t fifo_data;
	logic fifo_push;
	logic fifo_last;
	logic fifo_free;

	// Header and payload pushes take turns on the FIFO input
	assign fifo_data = ack_busy ? ack_data : seq_data;
	assign fifo_last = ack_busy ? ack_last : seq_last;
	assign fifo_push = ack_push | seq_push;

	frame_rx u_frame_rx (
		.rst(rst),
		.clk(clk),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.cmd(cmd_bus.rx)
	);

	basics_seq u_seq (
		.rst(rst),
		.clk(clk),
		.generate_nak(generate_nak),
		.cmd(cmd_bus.seq),
		.prm(prm_bus.seq),
		.ack_start(ack_start),
		.ack_nak(ack_nak),
		.ack_len(ack_len),
		.eid_out(ack_eid),
		.push_data(seq_data),
		.push(seq_push),
		.push_last(seq_last),
		.fifo_free(fifo_free),
		.frames_pending(resp_frame_valid)
	);

	param_bank u_bank (
		.rst(rst),
		.clk(clk),
		.gpio_read(gpio_read),
		.prm(prm_bus.bank),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.uart_baud_div(uart_baud_div)
	);

	ack_generator u_ack (
		.rst(rst),
		.clk(clk),
		.start(ack_start),
		.nak(ack_nak),
		.eid(ack_eid),
		.len(ack_len),
		.data(ack_data),
		.push(ack_push),
		.last(ack_last),
		.busy(ack_busy)
	);

	message_fifo u_fifo (
		.rst(rst),
		.clk(clk),
		.in_data(fifo_data),
		.in_last(fifo_last),
		.push(fifo_push),
		.pop(resp_pop),
		.out_data(resp_data),
		.out_last(resp_last),
		.frame_valid(resp_frame_valid),
		.free(fifo_free)
	);

endmodule

// ==== tb_basics.sv ====
module tb_basics;
	import basics_pkg::*;

	localparam int N_VER = 12;
	localparam int N_SET = 20;
	localparam int N_QUERY = 20;
	localparam int N_ODD = 12;
	localparam int N_B2B = 30;
	// One reset check plus every command frame
	localparam int NUM_TESTS = 1 + N_VER + N_SET + N_QUERY + N_ODD + N_B2B;
	localparam int CYCLES_PER_TEST = 400;

	// rst carries the clock and clk the reset
	logic rst;
	logic clk;
	logic generate_nak;
	byte_t ma_data;
	logic ma_data_valid;
	logic ma_frame_valid;
	gpio_t gpio_read;
	logic resp_pop;
	byte_t resp_data;
	logic resp_last;
	logic resp_frame_valid;
	i2c_speed_t i2c_speed;
	i2c_addr_t i2c_addr;
	gpio_t gpio_level;
	gpio_t gpio_direction;
	baud_div_t uart_baud_div;

	integer seed = 77;
	int n_pass;
	int n_fail;
	int test_pass;
	int test_fail;
	string cur_test;

	// Reference copy of the settings registers
	logic [7:0] m_speed;
	logic [15:0] m_addr;
	logic [23:0] m_level;
	logic [23:0] m_dir;
	logic [15:0] m_baud;

	// Expected bytes of all responses in flight in arrival order
	byte_t exp_data[$];
	logic exp_last[$];
	byte_t tx_pay[$];

	basics_int uut (
		.rst(rst),
		.clk(clk),
		.generate_nak(generate_nak),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.gpio_read(gpio_read),
		.resp_pop(resp_pop),
		.resp_data(resp_data),
		.resp_last(resp_last),
		.resp_frame_valid(resp_frame_valid),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.uart_baud_div(uart_baud_div)
	);

	initial begin
		rst = 1'b0;
		forever #5 rst = ~rst;
	end

	initial begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge rst);
		$display("Watchdog expired in %s, the DUT stopped responding", cur_test);
		$display("Test FAILED");
		$finish;
	end

	function automatic int unsigned rand_below(input int unsigned n);
		return {$random(seed)} % n;
	endfunction

	function automatic byte_t rand_byte();
		return byte_t'(rand_below(256));
	endfunction

	function automatic byte_t pick_sub();
		case (rand_below(5))
			0: return "c";
			1: return "a";
			2: return "l";
			3: return "d";
			default: return "b";
		endcase
	endfunction

	// Bytes held by a parameter
	function automatic int param_len(input byte_t sub);
		case (sub)
			"c": return 1;
			"a", "b": return 2;
			default: return 3;
		endcase
	endfunction

	// Level queries read the pins and not the level register
	function automatic logic [23:0] param_value(input byte_t sub);
		case (sub)
			"c": return {16'h0000, m_speed};
			"a": return {8'h00, m_addr};
			"l": return gpio_read;
			"d": return m_dir;
			default: return {8'h00, m_baud};
		endcase
	endfunction

	// Upper case letters query a group and lower case letters set it
	function automatic byte_t group_cmd(input byte_t sub, input logic is_set);
		byte_t q;
		case (sub)
			"c", "a": q = "I";
			"l", "d": q = "G";
			default: q = "P";
		endcase
		return is_set ? (q | 8'h20) : q;
	endfunction

	function automatic logic sub_valid(input byte_t cmd_b, input byte_t sub);
		case (cmd_b)
			"I", "i": return sub == "c" || sub == "a";
			"G", "g": return sub == "l" || sub == "d";
			default: return sub == "b";
		endcase
	endfunction

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) begin
			n_pass++;
		end else begin
			n_fail++;
			$display("FAIL %s %s expected %0h actual %0h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_settings();
		check_val("i2c_speed", m_speed, i2c_speed);
		check_val("i2c_addr", m_addr, i2c_addr);
		check_val("gpio_level", m_level, gpio_level);
		check_val("gpio_direction", m_dir, gpio_direction);
		check_val("uart_baud_div", m_baud, uart_baud_div);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_pass = n_pass;
		test_fail = n_fail;
	endtask

	task automatic end_test();
		$display("%s: %0d checks, %0d failed", cur_test,
			n_pass + n_fail - test_pass - test_fail, n_fail - test_fail);
	endtask

	task automatic drive_byte(input byte_t b);
		ma_data = b;
		ma_data_valid = 1'b1;
		@(negedge rst);
		ma_data_valid = 1'b0;
	endtask

	// Header bytes go back to back and payload bytes get random gaps
	task automatic send_frame(input byte_t cmd_b, input byte_t eid);
		ma_frame_valid = 1'b1;
		drive_byte(cmd_b);
		drive_byte(eid);
		drive_byte(byte_t'(tx_pay.size()));
		foreach (tx_pay[i]) begin
			repeat (rand_below(4)) @(negedge rst);
			drive_byte(tx_pay[i]);
		end
		ma_frame_valid = 1'b0;
		ma_data = 8'h00;
		@(negedge rst);
	endtask

	task automatic expect_header(input logic nak, input byte_t eid, input byte_t len);
		exp_data.push_back(nak ? 8'd1 : 8'd0);
		exp_last.push_back(1'b0);
		exp_data.push_back(eid);
		exp_last.push_back(1'b0);
		exp_data.push_back(len);
		exp_last.push_back(len == 8'd0);
	endtask

	// Most significant byte goes out first
	task automatic expect_payload(input logic [23:0] value, input int len);
		for (int i = len - 1; i >= 0; i--) begin
			exp_data.push_back(value[8*i +: 8]);
			exp_last.push_back(i == 0);
		end
	endtask

	task automatic ask_version();
		byte_t eid;
		byte_t major;
		byte_t minor;
		eid = rand_byte();
		if (rand_below(2) == 0) begin
			major = 8'd0;
			minor = 8'd3;
		end else begin
			major = byte_t'(rand_below(3));
			minor = byte_t'(rand_below(6));
		end
		tx_pay.delete();
		tx_pay.push_back(major);
		tx_pay.push_back(minor);
		if (major == 8'd0 && minor == 8'd3) begin
			expect_header(1'b0, eid, 8'd0);
		end else begin
			expect_header(1'b1, eid, 8'd2);
			expect_payload(24'h000003, 2);
		end
		send_frame("v", eid);
	endtask

	task automatic set_param();
		byte_t eid;
		byte_t sub;
		logic [23:0] value;
		int len;
		eid = rand_byte();
		sub = pick_sub();
		len = param_len(sub);
		value = {rand_byte(), rand_byte(), rand_byte()};
		tx_pay.delete();
		tx_pay.push_back(sub);
		for (int i = len - 1; i >= 0; i--) begin
			tx_pay.push_back(value[8*i +: 8]);
		end
		expect_header(1'b0, eid, 8'd0);
		send_frame(group_cmd(sub, 1'b1), eid);
		// Old settings hold until the ACK has been popped
		check_settings();
		case (sub)
			"c": m_speed = value[7:0];
			"a": m_addr = value[15:0];
			"l": m_level = value;
			"d": m_dir = value;
			default: m_baud = value[15:0];
		endcase
	endtask

	task automatic query_param();
		byte_t eid;
		byte_t sub;
		int len;
		eid = rand_byte();
		sub = pick_sub();
		len = param_len(sub);
		gpio_read = {rand_byte(), rand_byte(), rand_byte()};
		tx_pay.delete();
		tx_pay.push_back(sub);
		expect_header(1'b0, eid, byte_t'(len));
		expect_payload(param_value(sub), len);
		send_frame(group_cmd(sub, 1'b0), eid);
	endtask

	// Sub-parameter outside the command's group and sometimes trailing junk
	task automatic send_bad_sub();
		byte_t eid;
		byte_t cmd_b;
		byte_t sub;
		eid = rand_byte();
		cmd_b = group_cmd(pick_sub(), rand_below(2) == 1);
		do begin
			sub = rand_byte();
		end while (sub_valid(cmd_b, sub));
		tx_pay.delete();
		tx_pay.push_back(sub);
		repeat (rand_below(3)) tx_pay.push_back(rand_byte());
		expect_header(1'b1, eid, 8'd0);
		send_frame(cmd_b, eid);
	endtask

	// NAK request where the following frame only supplies the EID
	task automatic force_nak();
		byte_t eid;
		eid = rand_byte();
		expect_header(1'b1, eid, 8'd0);
		generate_nak = 1'b1;
		@(negedge rst);
		generate_nak = 1'b0;
		tx_pay.delete();
		send_frame(group_cmd(pick_sub(), rand_below(2) == 1), eid);
	endtask

	task automatic random_command();
		case (rand_below(5))
			0: ask_version();
			1: set_param();
			2: query_param();
			3: send_bad_sub();
			default: force_nak();
		endcase
	endtask

	task automatic drain_frame(input int max_gap);
		logic done;
		byte_t got_data;
		logic got_last;
		done = 1'b0;
		while (!done) begin
			repeat (rand_below(max_gap + 1)) @(negedge rst);
			while (!resp_frame_valid) @(negedge rst);
			got_data = resp_data;
			got_last = resp_last;
			assert (exp_data.size() > 0) else begin
				n_fail++;
				$display("%s: response byte %0h arrived with no frame expected",
					cur_test, got_data);
			end
			if (exp_data.size() > 0) begin
				check_val("resp_data", exp_data.pop_front(), got_data);
				check_val("resp_last", exp_last.pop_front(), got_last);
			end
			resp_pop = 1'b1;
			@(negedge rst);
			resp_pop = 1'b0;
			done = got_last;
		end
	endtask

	// IDLE is the first sequencer state
	task automatic wait_idle();
		while (uut.u_seq.state != 4'd0) @(negedge rst);
	endtask

	initial begin
		clk = 1'b1;
		generate_nak = 1'b0;
		ma_data = 8'h00;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		gpio_read = 24'h000000;
		resp_pop = 1'b0;
		n_pass = 0;
		n_fail = 0;
		cur_test = "reset";
		m_speed = 8'd99;
		m_addr = 16'hFFFF;
		m_level = 24'h000000;
		m_dir = 24'h000000;
		m_baud = 16'd174;
		repeat (3) @(negedge rst);
		clk = 1'b0;
		@(negedge rst);

		begin_test("reset");
		check_val("resp_frame_valid", 1'b0, resp_frame_valid);
		check_settings();
		end_test();

		begin_test("version");
		repeat (N_VER) begin
			ask_version();
			drain_frame(3);
			wait_idle();
		end
		end_test();

		begin_test("set");
		repeat (N_SET) begin
			set_param();
			drain_frame(3);
			wait_idle();
			check_settings();
		end
		end_test();

		begin_test("query");
		repeat (N_QUERY) begin
			query_param();
			drain_frame(3);
			wait_idle();
		end
		end_test();

		begin_test("nak");
		for (int i = 0; i < N_ODD; i++) begin
			if (i % 2 == 0)
				send_bad_sub();
			else
				force_nak();
			drain_frame(3);
			wait_idle();
			check_settings();
		end
		end_test();

		// Host keeps sending while the popper lags behind
		begin_test("back_to_back");
		fork
			begin
				repeat (N_B2B) begin
					wait_idle();
					random_command();
				end
			end
			begin
				repeat (N_B2B) drain_frame(8);
			end
		join
		wait_idle();
		check_settings();
		assert (exp_data.size() == 0) else begin
			n_fail++;
			$display("%s: %0d expected response bytes never arrived", cur_test, exp_data.size());
		end
		end_test();

		$display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== basics_int.f ====
basics_pkg.sv
basics_ifs.sv
frame_rx.sv
basics_seq.sv
param_bank.sv
ack_generator.sv
message_fifo.sv
basics_int.sv
tb_basics.sv

// ==== Bender.yml ====
package:
  name: basics_int

sources:
  - basics_pkg.sv
  - basics_ifs.sv
  - frame_rx.sv
  - basics_seq.sv
  - param_bank.sv
  - ack_generator.sv
  - message_fifo.sv
  - basics_int.sv
  - target: test
    files:
      - tb_basics.sv
